// File: design/dcache_config.svh
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// address and data widths
`define DC_ADDR_W 16
`define DC_WORD_W 32

// cache geometry
`define DC_WORDS 4
`define DC_SETS 16
`define DC_WAYS 2

// derived field widths of the byte address
`define DC_OFFSET_W 4
`define DC_INDEX_W 4
`define DC_TAG_W (`DC_ADDR_W - `DC_INDEX_W - `DC_OFFSET_W)

// one full line
`define DC_LINE_W (`DC_WORD_W * `DC_WORDS)

`endif

// File: design/dcache_pkg.sv
`include "dcache_config.svh"

package dcache_pkg;

  // --------------------
  // plain vector types
  // --------------------
  typedef logic [`DC_ADDR_W-1:0]   addr_t;
  typedef logic [`DC_WORD_W-1:0]   word_t;
  typedef logic [`DC_LINE_W-1:0]   line_t;
  typedef logic [`DC_TAG_W-1:0]    tag_t;
  typedef logic [`DC_INDEX_W-1:0]  index_t;
  // one-hot way select
  typedef logic [`DC_WAYS-1:0]     way_t;
  typedef logic [15:0]             count_t;
  typedef logic [`DC_WORD_W/8-1:0] be_t;

  // --------------------
  // port bundles
  // --------------------
  // core side request, fields stable while req is high
  typedef struct packed {
    logic  req;
    logic  we;
    addr_t addr;
    word_t wdata;
    be_t   be;
  } core_req_t;

  typedef struct packed {
    logic  ack;
    word_t rdata;
  } core_rsp_t;

  // line set for a full line transfer, clear for a single word
  typedef struct packed {
    logic  req;
    logic  we;
    logic  line;
    addr_t addr;
    line_t wline;
    word_t wword;
  } mem_req_t;

  typedef struct packed {
    logic  ack;
    line_t rline;
    word_t rword;
  } mem_rsp_t;

  // register access with a one cycle write strobe
  typedef struct packed {
    logic       wr;
    logic [1:0] addr;
    word_t      wdata;
  } cfg_req_t;

  // controller FSM
  typedef enum logic [2:0] {
    IDLE,
    LOOKUP,
    STORE,
    EVICT,
    REFILL,
    BYPASS,
    RESP
  } dc_state_e;

endpackage

// File: design/dcache_arrays.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_arrays
  import dcache_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  index_t rd_index_i,
  input  tag_t   lookup_tag_i,
  input  logic   wr_en_i,
  input  index_t wr_index_i,
  input  way_t   wr_way_i,
  input  tag_t   wr_tag_i,
  input  line_t  wr_line_i,
  input  logic   wr_dirty_i,
  input  logic   touch_i,
  input  way_t   touch_way_i,
  output way_t   hit_way_o,
  output line_t  rd_line_o,
  output way_t   victim_way_o,
  output logic   victim_dirty_o,
  output tag_t   victim_tag_o,
  output line_t  victim_line_o
);

  localparam int unsigned Ways = `DC_WAYS;
  localparam int unsigned Sets = `DC_SETS;

  // storage per way
  tag_t  tag_mem  [Ways][Sets];
  line_t data_mem [Ways][Sets];
  logic [Ways-1:0][Sets-1:0] valid_q;
  logic [Ways-1:0][Sets-1:0] dirty_q;
  // one bit per set, set means way 1 is least recently used
  logic [Sets-1:0] lru_q;

  // read port registers
  index_t rd_index_q;
  tag_t   rd_tag_q  [Ways];
  line_t  rd_line_q [Ways];
  way_t   rd_valid_q;
  way_t   rd_dirty_q;

  // --------------------
  // tag and data arrays
  // --------------------
  always_ff @(posedge clk_i) begin
    rd_index_q <= rd_index_i;
    for (int w = 0; w < Ways; w++) begin
      if (wr_en_i && wr_way_i[w]) begin
        tag_mem[w][wr_index_i]  <= wr_tag_i;
        data_mem[w][wr_index_i] <= wr_line_i;
      end
      // synchronous read of the requested set
      rd_tag_q[w]  <= tag_mem[w][rd_index_i];
      rd_line_q[w] <= data_mem[w][rd_index_i];
    end
  end

  // state bits
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q    <= '0;
      dirty_q    <= '0;
      rd_valid_q <= '0;
      rd_dirty_q <= '0;
    end else begin
      for (int w = 0; w < Ways; w++) begin
        if (wr_en_i && wr_way_i[w]) begin
          valid_q[w][wr_index_i] <= 1'b1;
          dirty_q[w][wr_index_i] <= wr_dirty_i;
        end
        rd_valid_q[w] <= valid_q[w][rd_index_i];
        rd_dirty_q[w] <= dirty_q[w][rd_index_i];
      end
    end
  end

  // touch applies to the set that was read last
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      lru_q <= '0;
    end else if (touch_i) begin
      lru_q[rd_index_q] <= touch_way_i[0];
    end
  end

  // --------------------
  // compare and select
  // --------------------
  always_comb begin
    rd_line_o = '0;
    for (int w = 0; w < Ways; w++) begin
      hit_way_o[w] = rd_valid_q[w] && (rd_tag_q[w] == lookup_tag_i);
      if (hit_way_o[w]) rd_line_o = rd_line_q[w];
    end
  end

  always_comb begin
    // lru way unless some way is still empty
    victim_way_o = lru_q[rd_index_q] ? way_t'(2) : way_t'(1);
    for (int w = Ways - 1; w >= 0; w--) begin
      if (!rd_valid_q[w]) victim_way_o = way_t'(1) << w;
    end
    victim_dirty_o = 1'b0;
    victim_tag_o   = '0;
    victim_line_o  = '0;
    for (int w = 0; w < Ways; w++) begin
      if (victim_way_o[w]) begin
        victim_dirty_o = rd_valid_q[w] && rd_dirty_q[w];
        victim_tag_o   = rd_tag_q[w];
        victim_line_o  = rd_line_q[w];
      end
    end
  end

  // the controller never installs a tag that is already present in the set
  a_hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(hit_way_o))
    else $error("tag hit in more than one way");

endmodule

// File: design/dcache_ctrl.sv
`timescale 1ns/1ns
`include "dcache_config.svh"

module dcache_ctrl
  import dcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core port
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  input  logic      bypass_i,
  // array read side
  output index_t    rd_index_o,
  output tag_t      lookup_tag_o,
  input  way_t      hit_way_i,
  input  line_t     rd_line_i,
  input  way_t      victim_way_i,
  input  logic      victim_dirty_i,
  input  tag_t      victim_tag_i,
  input  line_t     victim_line_i,
  // array write side
  output logic      wr_en_o,
  output index_t    wr_index_o,
  output way_t      wr_way_o,
  output tag_t      wr_tag_o,
  output line_t     wr_line_o,
  output logic      wr_dirty_o,
  output logic      touch_o,
  output way_t      touch_way_o,
  // memory port
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i,
  // to the counters
  output logic      hit_o,
  output logic      miss_o
);

  localparam int unsigned ByteOffW = $clog2(`DC_WORD_W / 8);
  localparam int unsigned WordSelW = $clog2(`DC_WORDS);

  typedef logic [WordSelW-1:0] wsel_t;

  dc_state_e state_q, state_d;
  // memory ack seen and waiting for it to drop
  logic      mem_done_q, mem_done_d;
  core_req_t req_q;
  way_t      way_q;
  line_t     line_q;
  word_t     rdata_q;

  tag_t   req_tag;
  index_t req_index;
  wsel_t  req_wsel;
  logic   mem_first_ack;

  assign req_tag   = req_q.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
  assign req_index = req_q.addr[`DC_OFFSET_W +: `DC_INDEX_W];
  assign req_wsel  = req_q.addr[ByteOffW +: WordSelW];
  assign mem_first_ack = mem_rsp_i.ack && !mem_done_q;

  function automatic word_t get_word(line_t line, wsel_t sel);
    return line[sel * `DC_WORD_W +: `DC_WORD_W];
  endfunction

  // byte merge of the store data into one word of the line
  function automatic line_t merge_word(line_t line, wsel_t sel, be_t be, word_t wdata);
    line_t merged;
    merged = line;
    for (int b = 0; b < `DC_WORD_W / 8; b++) begin
      if (be[b]) merged[sel * `DC_WORD_W + b * 8 +: 8] = wdata[b * 8 +: 8];
    end
    return merged;
  endfunction

  assign core_rsp_o.ack   = (state_q == RESP);
  assign core_rsp_o.rdata = rdata_q;
  assign lookup_tag_o     = req_tag;
  // new index in IDLE, otherwise hold the set of the access in flight
  assign rd_index_o = (state_q == IDLE) ? core_req_i.addr[`DC_OFFSET_W +: `DC_INDEX_W]
                                        : req_index;

  // --------------------
  // cache FSM
  // --------------------
  always_comb begin
    state_d     = state_q;
    mem_done_d  = mem_done_q;
    wr_en_o     = 1'b0;
    wr_index_o  = req_index;
    wr_way_o    = way_q;
    wr_tag_o    = req_tag;
    wr_line_o   = mem_rsp_i.rline;
    wr_dirty_o  = 1'b0;
    touch_o     = 1'b0;
    touch_way_o = way_q;
    mem_req_o   = '0;
    hit_o       = 1'b0;
    miss_o      = 1'b0;

    case (state_q)
      IDLE: begin
        if (core_req_i.req) state_d = bypass_i ? BYPASS : LOOKUP;
      end
      LOOKUP: begin
        if (|hit_way_i) begin
          hit_o       = 1'b1;
          touch_o     = 1'b1;
          touch_way_o = hit_way_i;
          state_d     = req_q.we ? STORE : RESP;
        end else begin
          miss_o  = 1'b1;
          state_d = victim_dirty_i ? EVICT : REFILL;
        end
      end
      STORE: begin
        wr_en_o    = 1'b1;
        wr_line_o  = merge_word(line_q, req_wsel, req_q.be, req_q.wdata);
        wr_dirty_o = 1'b1;
        state_d    = RESP;
      end
      EVICT: begin
        // write back the dirty victim line
        mem_req_o.req   = !mem_done_q;
        mem_req_o.we    = 1'b1;
        mem_req_o.line  = 1'b1;
        mem_req_o.addr  = {victim_tag_i, req_index, {`DC_OFFSET_W{1'b0}}};
        mem_req_o.wline = victim_line_i;
        if (mem_rsp_i.ack) begin
          mem_done_d = 1'b1;
        end else if (mem_done_q) begin
          mem_done_d = 1'b0;
          state_d    = REFILL;
        end
      end
      REFILL: begin
        mem_req_o.req  = !mem_done_q;
        mem_req_o.line = 1'b1;
        mem_req_o.addr = {req_tag, req_index, {`DC_OFFSET_W{1'b0}}};
        // install clean on the first ack cycle
        if (mem_first_ack) begin
          wr_en_o = 1'b1;
          touch_o = 1'b1;
        end
        if (mem_rsp_i.ack) begin
          mem_done_d = 1'b1;
        end else if (mem_done_q) begin
          mem_done_d = 1'b0;
          // a pending store goes through STORE on the fresh line
          state_d    = req_q.we ? STORE : RESP;
        end
      end
      BYPASS: begin
        mem_req_o.req   = !mem_done_q;
        mem_req_o.we    = req_q.we;
        mem_req_o.addr  = req_q.addr;
        mem_req_o.wword = req_q.wdata;
        if (mem_rsp_i.ack) begin
          mem_done_d = 1'b1;
        end else if (mem_done_q) begin
          mem_done_d = 1'b0;
          state_d    = RESP;
        end
      end
      RESP: begin
        // hold ack until the core drops req
        if (!core_req_i.req) state_d = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= IDLE;
      mem_done_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      mem_done_q <= mem_done_d;
    end
  end

  // request, way, line and load data
  always_ff @(posedge clk_i) begin
    case (state_q)
      IDLE: req_q <= core_req_i;
      LOOKUP: begin
        way_q   <= (|hit_way_i) ? hit_way_i : victim_way_i;
        line_q  <= rd_line_i;
        rdata_q <= get_word(rd_line_i, req_wsel);
      end
      REFILL: begin
        if (mem_first_ack) begin
          line_q  <= mem_rsp_i.rline;
          rdata_q <= get_word(mem_rsp_i.rline, req_wsel);
        end
      end
      BYPASS: begin
        if (mem_first_ack) rdata_q <= mem_rsp_i.rword;
      end
      default: ;
    endcase
  end

  // --------------------
  // handshake checks
  // --------------------
  a_ack_needs_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(core_rsp_o.ack) |-> $past(core_req_i.req))
    else $error("core ack raised without a request");

  a_mem_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (mem_req_o.req && !mem_rsp_i.ack) |=> $stable(mem_req_o))
    else $error("memory request changed before ack");

endmodule

// File: design/dcache_cfg_regs.sv
`timescale 1ns/1ns

module dcache_cfg_regs
  import dcache_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  cfg_req_t cfg_req_i,
  input  logic     hit_i,
  input  logic     miss_i,
  output logic     bypass_o,
  output word_t    cfg_rdata_o
);

  localparam logic [1:0] RegBypass = 2'd0;
  localparam logic [1:0] RegHits   = 2'd1;
  localparam logic [1:0] RegMisses = 2'd2;

  logic   bypass_q;
  // counter 0 counts hits and counter 1 misses
  count_t cnt_q [2];
  logic [1:0] cnt_inc;
  logic [1:0] cnt_clr;

  assign cnt_inc = {miss_i, hit_i};
  assign cnt_clr[0] = cfg_req_i.wr && (cfg_req_i.addr == RegHits);
  assign cnt_clr[1] = cfg_req_i.wr && (cfg_req_i.addr == RegMisses);
  assign bypass_o = bypass_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bypass_q <= 1'b0;
    end else if (cfg_req_i.wr && (cfg_req_i.addr == RegBypass)) begin
      bypass_q <= cfg_req_i.wdata[0];
    end
  end

  // saturating counters, a write clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int c = 0; c < 2; c++) cnt_q[c] <= '0;
    end else begin
      for (int c = 0; c < 2; c++) begin
        if (cnt_clr[c]) cnt_q[c] <= '0;
        else if (cnt_inc[c] && (cnt_q[c] != '1)) cnt_q[c] <= cnt_q[c] + 1'b1;
      end
    end
  end

  // combinational read
  always_comb begin
    case (cfg_req_i.addr)
      RegBypass: cfg_rdata_o = word_t'(bypass_q);
      RegHits:   cfg_rdata_o = word_t'(cnt_q[0]);
      RegMisses: cfg_rdata_o = word_t'(cnt_q[1]);
      default:   cfg_rdata_o = '0;
    endcase
  end

endmodule

// File: design/dcache_top.sv
`timescale 1ns/1ns

module dcache_top
  import dcache_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  // core port
  input  core_req_t core_req_i,
  output core_rsp_t core_rsp_o,
  // memory port
  output mem_req_t  mem_req_o,
  input  mem_rsp_t  mem_rsp_i,
  // configuration port
  input  cfg_req_t  cfg_req_i,
  output word_t     cfg_rdata_o
);

  // array read side
  index_t rd_index;
  tag_t   lookup_tag;
  way_t   hit_way;
  line_t  rd_line;
  way_t   victim_way;
  logic   victim_dirty;
  tag_t   victim_tag;
  line_t  victim_line;
  // array write side
  logic   wr_en;
  index_t wr_index;
  way_t   wr_way;
  tag_t   wr_tag;
  line_t  wr_line;
  logic   wr_dirty;
  logic   touch;
  way_t   touch_way;
  // counters and mode
  logic   hit;
  logic   miss;
  logic   bypass;

  // --------------------
  // controller
  // --------------------
  dcache_ctrl dcache_ctrl_i (
    .clk_i, .rst_ni, .core_req_i, .core_rsp_o,
    .bypass_i (bypass),
    .rd_index_o (rd_index), .lookup_tag_o (lookup_tag),
    .hit_way_i (hit_way), .rd_line_i (rd_line),
    .victim_way_i (victim_way), .victim_dirty_i (victim_dirty),
    .victim_tag_i (victim_tag), .victim_line_i (victim_line),
    .wr_en_o (wr_en), .wr_index_o (wr_index), .wr_way_o (wr_way),
    .wr_tag_o (wr_tag), .wr_line_o (wr_line), .wr_dirty_o (wr_dirty),
    .touch_o (touch), .touch_way_o (touch_way),
    .mem_req_o, .mem_rsp_i,
    .hit_o (hit), .miss_o (miss)
  );

  dcache_arrays dcache_arrays_i (
    .clk_i, .rst_ni,
    .rd_index_i (rd_index), .lookup_tag_i (lookup_tag),
    .wr_en_i (wr_en), .wr_index_i (wr_index), .wr_way_i (wr_way),
    .wr_tag_i (wr_tag), .wr_line_i (wr_line), .wr_dirty_i (wr_dirty),
    .touch_i (touch), .touch_way_i (touch_way),
    .hit_way_o (hit_way), .rd_line_o (rd_line),
    .victim_way_o (victim_way), .victim_dirty_o (victim_dirty),
    .victim_tag_o (victim_tag), .victim_line_o (victim_line)
  );

  // bypass enable and counters
  dcache_cfg_regs dcache_cfg_regs_i (
    .clk_i, .rst_ni, .cfg_req_i,
    .hit_i (hit), .miss_i (miss),
    .bypass_o (bypass), .cfg_rdata_o
  );

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ns

module tb_mem_model
  import dcache_pkg::*;
(
  input  logic        clk_i,
  input  logic        rst_ni,
  input  mem_req_t    mem_req_i,
  output mem_rsp_t    mem_rsp_o,
  // transfer counts seen so far
  output int unsigned line_wr_o,
  output int unsigned line_rd_o,
  output int unsigned word_wr_o,
  output int unsigned word_rd_o
);

  typedef logic [13:0] waddr_t;

  // sparse word store, untouched words read the fill pattern
  word_t       mem_q [waddr_t];
  int unsigned delay_q;

  // initial content, every bit of the word address shows up
  function automatic word_t fill_word(waddr_t waddr);
    return {2'b10, waddr, ~waddr, 2'b01};
  endfunction

  function automatic word_t read_word(waddr_t waddr);
    if (mem_q.exists(waddr)) return mem_q[waddr];
    return fill_word(waddr);
  endfunction

  // word 0 of the line sits in the low bits
  function automatic line_t read_line(waddr_t base);
    line_t line;
    for (int w = 0; w < 4; w++) line[w * 32 +: 32] = read_word(base + waddr_t'(w));
    return line;
  endfunction

  task automatic write_line(input waddr_t base, input line_t line);
    for (int w = 0; w < 4; w++) mem_q[base + waddr_t'(w)] = line[w * 32 +: 32];
  endtask

  // --------------------
  // four-phase responder
  // --------------------
  // answers on the falling edge, after a random wait of 0 to 3 cycles
  always @(negedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_rsp_o <= '0;
      delay_q   <= 0;
      line_wr_o <= 0;
      line_rd_o <= 0;
      word_wr_o <= 0;
      word_rd_o <= 0;
    end else if (mem_rsp_o.ack) begin
      // ack stays up until the request drops
      if (!mem_req_i.req) begin
        mem_rsp_o.ack <= 1'b0;
        delay_q       <= $urandom_range(3, 0);
      end
    end else if (mem_req_i.req) begin
      if (delay_q != 0) begin
        delay_q <= delay_q - 1;
      end else if (mem_req_i.line && mem_req_i.we) begin
        write_line({mem_req_i.addr[15:4], 2'b00}, mem_req_i.wline);
        line_wr_o     <= line_wr_o + 1;
        mem_rsp_o.ack <= 1'b1;
      end else if (mem_req_i.line) begin
        mem_rsp_o.rline <= read_line({mem_req_i.addr[15:4], 2'b00});
        line_rd_o       <= line_rd_o + 1;
        mem_rsp_o.ack   <= 1'b1;
      end else if (mem_req_i.we) begin
        // single word, always written whole
        mem_q[mem_req_i.addr[15:2]] = mem_req_i.wword;
        word_wr_o     <= word_wr_o + 1;
        mem_rsp_o.ack <= 1'b1;
      end else begin
        mem_rsp_o.rword <= read_word(mem_req_i.addr[15:2]);
        word_rd_o       <= word_rd_o + 1;
        mem_rsp_o.ack   <= 1'b1;
      end
    end
  end

endmodule

// File: testbench/tb_dcache_top.sv
`timescale 1ns/1ns

module tb_dcache_top
  import dcache_pkg::*;
();

  localparam int unsigned Timeout   = 100;
  localparam int unsigned RandomOps = 200;

  typedef logic [13:0] waddr_t;

  // what the response to one access must carry
  typedef struct packed {
    logic  is_load;
    addr_t addr;
    word_t value;
  } expect_t;

  logic        clk;
  logic        rst_n;
  core_req_t   core_req;
  core_rsp_t   core_rsp;
  mem_req_t    mem_req;
  mem_rsp_t    mem_rsp;
  cfg_req_t    cfg_req;
  word_t       cfg_rdata;
  int unsigned line_wr;
  int unsigned line_rd;
  int unsigned word_wr;
  int unsigned word_rd;

  // every word the core has written, by word address
  word_t       shadow [waddr_t];
  expect_t     exp_q [$];
  expect_t     exp_head;
  logic        ack_prev;
  int unsigned checks;
  int unsigned mismatches;
  int unsigned failures;

  dcache_top dcache_top_i (
    .clk_i (clk), .rst_ni (rst_n),
    .core_req_i (core_req), .core_rsp_o (core_rsp),
    .mem_req_o (mem_req), .mem_rsp_i (mem_rsp),
    .cfg_req_i (cfg_req), .cfg_rdata_o (cfg_rdata)
  );

  tb_mem_model mem_model_i (
    .clk_i (clk), .rst_ni (rst_n), .mem_req_i (mem_req), .mem_rsp_o (mem_rsp),
    .line_wr_o (line_wr), .line_rd_o (line_rd), .word_wr_o (word_wr), .word_rd_o (word_rd)
  );

  always #10 clk = ~clk;

  // --------------------
  // reference model
  // --------------------
  // memory content before any store
  function automatic word_t fill_word(waddr_t waddr);
    return {2'b10, waddr, ~waddr, 2'b01};
  endfunction

  function automatic word_t ref_load(addr_t addr);
    if (shadow.exists(addr[15:2])) return shadow[addr[15:2]];
    return fill_word(addr[15:2]);
  endfunction

  function automatic word_t merge_bytes(word_t old, word_t wdata, be_t be);
    word_t merged;
    merged = old;
    for (int b = 0; b < 4; b++) if (be[b]) merged[b * 8 +: 8] = wdata[b * 8 +: 8];
    return merged;
  endfunction

  task automatic check_value(input string name, input word_t actual, input word_t expected);
    checks++;
    if (actual !== expected) begin
      mismatches++;
      $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
    end
  endtask

  task automatic report_failure(input string what);
    failures++;
    $display("Error at %0t ns: %s", $time, what);
  endtask

  // one four-phase access, starting and ending on a falling edge
  task automatic core_access(input logic we, input addr_t addr, input word_t wdata,
                             input be_t be, input int unsigned hold,
                             output int unsigned latency);
    int unsigned fall_cnt;
    expect_t     exp;
    exp.is_load = !we;
    exp.addr    = addr;
    exp.value   = we ? '0 : ref_load(addr);
    if (we) shadow[addr[15:2]] = merge_bytes(ref_load(addr), wdata, be);
    exp_q.push_back(exp);
    core_req.we    = we;
    core_req.addr  = addr;
    core_req.wdata = wdata;
    core_req.be    = be;
    core_req.req   = 1'b1;
    latency = 0;
    while (!core_rsp.ack && latency < Timeout) begin
      @(negedge clk);
      latency++;
    end
    if (!core_rsp.ack) begin
      report_failure($sformatf("no core ack for the access to %h", addr));
    end else begin
      // a core that keeps req up must see ack stay up
      for (int unsigned h = 0; h < hold; h++) begin
        @(negedge clk);
        check_value("core_rsp.ack while req held", word_t'(core_rsp.ack), 1);
      end
    end
    core_req.req = 1'b0;
    fall_cnt = 0;
    while (core_rsp.ack && fall_cnt < Timeout) begin
      @(negedge clk);
      fall_cnt++;
    end
    if (core_rsp.ack) report_failure("core ack did not fall after req fell");
    else check_value("cycles from req low to ack low", word_t'(fall_cnt), 1);
  endtask

  task automatic cfg_write(input logic [1:0] addr, input word_t wdata);
    cfg_req.wr    = 1'b1;
    cfg_req.addr  = addr;
    cfg_req.wdata = wdata;
    @(negedge clk);
    cfg_req.wr = 1'b0;
  endtask

  task automatic cfg_read(input logic [1:0] addr, output word_t value);
    cfg_req.addr = addr;
    @(negedge clk);
    value = cfg_rdata;
  endtask

  // --------------------
  // response compare
  // --------------------
  // each rising ack retires the oldest access and checks a load against ref_load
  always @(negedge clk) begin
    if (rst_n && core_rsp.ack && !ack_prev) begin
      if (exp_q.size() == 0) begin
        report_failure("core ack without an access in flight");
      end else begin
        exp_head = exp_q.pop_front();
        if (exp_head.is_load)
          check_value($sformatf("core_rsp.rdata of %h", exp_head.addr), core_rsp.rdata,
                      exp_head.value);
      end
    end
    ack_prev = core_rsp.ack;
  end

  // --------------------
  // stimulus
  // --------------------
  initial begin
    word_t       value;
    int unsigned latency;
    int unsigned wb_before;
    int unsigned wr_before;
    int unsigned rd_before;
    int unsigned lines_before;
    addr_t       addr;
    void'($urandom(88));
    clk        = 1'b0;
    rst_n      = 1'b0;
    core_req   = '0;
    cfg_req    = '0;
    ack_prev   = 1'b0;
    checks     = 0;
    mismatches = 0;
    failures   = 0;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    // cold miss, then a hit on the same word
    core_access(1'b0, 16'h0104, '0, '0, 0, latency);
    core_access(1'b0, 16'h0104, '0, '0, 0, latency);
    check_value("load hit latency", word_t'(latency), 2);
    cfg_read(2'd1, value);
    check_value("hit counter", value, 1);
    cfg_read(2'd2, value);
    check_value("miss counter", value, 1);

    // partial store into the now cached line, then read it back
    core_access(1'b1, 16'h0108, 32'hA1B2_C3D4, 4'b0101, 0, latency);
    check_value("store hit latency", word_t'(latency), 3);
    core_access(1'b0, 16'h0108, '0, '0, 0, latency);

    // three tags in set 3 against two ways
    wb_before = line_wr;
    for (int i = 0; i < 3; i++) begin
      addr = {4'(i + 1), 4'h2, 4'h3, 4'h0};
      core_access(1'b1, addr, $urandom, 4'hF, 0, latency);
    end
    core_access(1'b0, 16'h2230, '0, '0, 0, latency);
    core_access(1'b0, 16'h1230, '0, '0, 0, latency);
    core_access(1'b0, 16'h3230, '0, '0, 0, latency);
    // LRU order evicts the lines of 1230, 3230 and 2230 while still dirty
    check_value("line write-backs in set 3", word_t'(line_wr - wb_before), 3);

    // uncached region with bypass on
    wr_before    = word_wr;
    rd_before    = word_rd;
    lines_before = line_rd + line_wr;
    cfg_write(2'd0, 1);
    cfg_read(2'd0, value);
    check_value("bypass enable", value, 1);
    core_access(1'b1, 16'hF040, $urandom, 4'hF, 0, latency);
    core_access(1'b0, 16'hF040, '0, '0, 0, latency);
    core_access(1'b0, 16'hF044, '0, '0, 0, latency);
    cfg_write(2'd0, 0);
    check_value("word writes to memory", word_t'(word_wr - wr_before), 1);
    check_value("word reads from memory", word_t'(word_rd - rd_before), 2);
    check_value("line transfers during bypass", word_t'(line_rd + line_wr - lines_before), 0);
    // four hits and six misses from the cached accesses so far
    cfg_read(2'd1, value);
    check_value("hit counter after bypass", value, 4);
    cfg_read(2'd2, value);
    check_value("miss counter after bypass", value, 6);

    // random traffic over six tags and four sets
    for (int i = 0; i < RandomOps; i++) begin
      addr = {8'($urandom_range(5, 0)), 4'($urandom_range(3, 0)),
              2'($urandom_range(3, 0)), 2'b00};
      core_access(1'($urandom_range(1, 0)), addr, $urandom, 4'($urandom_range(15, 0)),
                  $urandom_range(2, 0), latency);
    end

    if (exp_q.size() != 0) report_failure("accesses left without a response");
    $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// File: all.f
+incdir+design
design/dcache_pkg.sv
design/dcache_arrays.sv
design/dcache_ctrl.sv
design/dcache_cfg_regs.sv
design/dcache_top.sv
testbench/tb_mem_model.sv
testbench/tb_dcache_top.sv

// File: Makefile
VERILATOR  := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only -Wall
TOP        := tb_dcache_top
RTL_TOP    := dcache_top
FILELIST   := all.f
BUILD_DIR  := obj_dir
LOG        := sim.log

# include paths and design sources only, for linting the RTL on its own
RTL_ARGS := $(filter +incdir+% design/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --Mdir $(BUILD_DIR) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)" && exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_ARGS)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
